/* src.f */
+incdir+tests
source/mshr_cfg_pkg.sv
source/mshr_entry_pkg.sv
source/mshr_port_if.sv
source/mshr_req_decode.sv
source/mshr_entry_store.sv
source/mshr_lookup.sv
source/mshr_top.sv
tests/mshr_tb.sv

/* Makefile */
TOP := mshr_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module mshr_top
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing -f src.f --top-module $(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

/* tests/mshr_tb_checks.svh */
/*
 * Typed compare tasks for the MSHR testbench. The first mismatch ends the run.
 */
`ifndef MSHR_TB_CHECKS_SVH
`define MSHR_TB_CHECKS_SVH

task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
endtask

task automatic check_flag(input string test, input string what,
                          input logic exp, input logic act);
    if (act !== exp) begin
        $display("** Error %s: %s expected %b, actual %b", test, what, exp, act);
        abort_run();
    end
endtask

task automatic check_way(input string test, input mshr_way_t exp, input mshr_way_t act);
    if (act !== exp) begin
        $display("** Error %s: alloc_way_o expected %0d, actual %0d", test, exp, act);
        abort_run();
    end
endtask

task automatic check_entry(input string test, input mshr_entry_t exp, input mshr_entry_t act);
    if (act !== exp) begin
        $display("** Error %s: ack record expected %h, actual %h", test, exp, act);
        abort_run();
    end
endtask

task automatic check_cache_set(input string test, input cache_set_t exp, input cache_set_t act);
    if (act !== exp) begin
        $display("** Error %s: ack_cache_set_o expected %h, actual %h", test, exp, act);
        abort_run();
    end
endtask

`endif

/* tests/mshr_tb.sv */
/*
 * One table row is issued per clock; its results are sampled mid-cycle after the
 * edge that executes it. The table never allocates into a full set.
 */
`timescale 1ns/10ps

module mshr_tb
    import mshr_cfg_pkg::*, mshr_entry_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;

    // Expected {empty_o, full_o}
    localparam logic [1:0] EMPTY = 2'b10;
    localparam logic [1:0] BUSY  = 2'b00;
    localparam logic [1:0] FULL  = 2'b01;

    // A miss is its record plus the cache set; the line is {tag, cache set}
    typedef struct packed {
        mshr_entry_t entry;
        cache_set_t  cset;
    } miss_t;

    typedef struct packed {
        logic       alloc;
        logic       check;
        logic       ack;
        miss_t      stim;
        mshr_set_t  ack_set;
        mshr_way_t  ack_way;
        mshr_way_t  exp_way;
        logic       exp_hit;
        logic       exp_afull;
        miss_t      exp_miss;
        logic [1:0] exp_flags;
    } row_t;

    // A and B share MSHR set 1; C has A's tag but another cache set in set 1
    localparam miss_t LINE_A = '{'{6'h05, 4'h3, 2'h1, 2'h2, 2'h1, 1'b1}, 6'h01};
    localparam miss_t LINE_B = '{'{6'h0a, 4'hc, 2'h2, 2'h1, 2'h3, 1'b0}, 6'h05};
    localparam miss_t LINE_C = '{'{6'h05, 4'h0, 2'h0, 2'h0, 2'h0, 1'b0}, 6'h09};
    localparam miss_t LINE_D = '{'{6'h05, 4'h0, 2'h0, 2'h0, 2'h0, 1'b0}, 6'h02};
    localparam miss_t LINE_E = '{'{6'h3f, 4'h7, 2'h3, 2'h3, 2'h2, 1'b1}, 6'h3d};
    localparam miss_t LINE_F = '{'{6'h11, 4'h9, 2'h0, 2'h1, 2'h0, 1'b1}, 6'h03};

    logic       clk_i;
    logic       rst_ni;
    logic       check_i;
    nline_t     check_nline_i;
    logic       alloc_i;
    nline_t     alloc_nline_i;
    req_id_t    alloc_req_id_i;
    src_id_t    alloc_src_id_i;
    word_t      alloc_word_i;
    cache_way_t alloc_victim_way_i;
    logic       alloc_need_rsp_i;
    logic       ack_i;
    mshr_set_t  ack_set_i;
    mshr_way_t  ack_way_i;
    logic       empty_o;
    logic       full_o;
    logic       hit_o;
    logic       alloc_full_o;
    mshr_way_t  alloc_way_o;
    req_id_t    ack_req_id_o;
    src_id_t    ack_src_id_o;
    word_t      ack_word_o;
    cache_way_t ack_cache_way_o;
    tag_t       ack_cache_tag_o;
    cache_set_t ack_cache_set_o;
    logic       ack_need_rsp_o;

    row_t  rows [$];
    string names [$];
    miss_t fill [MSHR_SETS][MSHR_WAYS];
    int    seed        = 32'h95898e0c;
    logic  table_ready = 1'b0;

    mshr_top DUT (.*);

    `include "mshr_tb_checks.svh"

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    task automatic push_row(input string name, input logic [2:0] req, input miss_t stim,
                            input mshr_set_t ack_set, input mshr_way_t ack_way,
                            input mshr_way_t exp_way, input logic [1:0] lookup,
                            input miss_t exp_miss, input logic [1:0] flags);
        row_t r;
        r = '{req[2], req[1], req[0], stim, ack_set, ack_way, exp_way,
              lookup[1], lookup[0], exp_miss, flags};
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic add_alloc(input string name, input miss_t m, input mshr_way_t way,
                             input logic [1:0] flags);
        push_row(name, 3'b100, m, '0, '0, way, 2'b00, '0, flags);
    endtask

    task automatic add_check(input string name, input miss_t m, input logic hit,
                             input logic afull, input logic [1:0] flags);
        push_row(name, 3'b010, m, '0, '0, '0, {hit, afull}, '0, flags);
    endtask

    task automatic add_ack(input string name, input mshr_set_t ack_set, input mshr_way_t way,
                           input miss_t m, input logic [1:0] flags);
        push_row(name, 3'b001, '0, ack_set, way, '0, 2'b00, m, flags);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        add_check("reset_check_a", LINE_A, 1'b0, 1'b0, EMPTY);
        add_check("reset_check_d", LINE_D, 1'b0, 1'b0, EMPTY);
        add_alloc("alloc_a", LINE_A, 1'b0, BUSY);
        add_alloc("alloc_b", LINE_B, 1'b1, BUSY);
        add_check("hit_a", LINE_A, 1'b1, 1'b1, BUSY);
        add_check("hit_b", LINE_B, 1'b1, 1'b1, BUSY);
        add_check("miss_same_tag_c", LINE_C, 1'b0, 1'b1, BUSY);
        add_check("miss_other_set_d", LINE_D, 1'b0, 1'b0, BUSY);
        add_ack("ack_a", 2'd1, 1'b0, LINE_A, BUSY);
        add_check("miss_after_ack_a", LINE_A, 1'b0, 1'b0, BUSY);
        add_check("hit_b_after_ack_a", LINE_B, 1'b1, 1'b0, BUSY);
        add_alloc("realloc_e", LINE_E, 1'b0, BUSY);
        add_check("hit_e", LINE_E, 1'b1, 1'b1, BUSY);
        // Acknowledge of B and allocate of F in the same cycle
        push_row("ack_beats_alloc", 3'b101, LINE_F, 2'd1, 1'b1, 1'b0, 2'b00, LINE_B, BUSY);
        add_check("alloc_f_dropped", LINE_F, 1'b0, 1'b0, BUSY);
        add_check("miss_after_ack_b", LINE_B, 1'b0, 1'b0, BUSY);
        // Random records in every free slot; E already holds set 1 way 0
        for (int s = 0; s < MSHR_SETS; s++) begin
            for (int w = 0; w < MSHR_WAYS; w++) begin
                if (s == 1 && w == 0) begin
                    fill[s][w] = LINE_E;
                end else begin
                    rnd = $random(seed);
                    fill[s][w] = rnd[$bits(miss_t)-1:0];
                    fill[s][w].cset[MSHR_SET_W-1:0] = mshr_set_t'(s);
                    add_alloc($sformatf("fill_s%0d_w%0d", s, w), fill[s][w], mshr_way_t'(w),
                              (s == 3 && w == 1) ? FULL : BUSY);
                end
            end
        end
        add_check("hit_last_fill", fill[3][1], 1'b1, 1'b1, FULL);
        for (int s = 0; s < MSHR_SETS; s++) begin
            for (int w = 0; w < MSHR_WAYS; w++) begin
                add_ack($sformatf("drain_s%0d_w%0d", s, w), mshr_set_t'(s), mshr_way_t'(w),
                        fill[s][w], (s == 3 && w == 1) ? EMPTY : BUSY);
            end
        end
        add_check("empty_check_a", LINE_A, 1'b0, 1'b0, EMPTY);
    endtask

    task automatic drive_row(input row_t r);
        alloc_i            <= r.alloc;
        check_i            <= r.check;
        ack_i              <= r.ack;
        alloc_nline_i      <= {r.stim.entry.tag, r.stim.cset};
        check_nline_i      <= {r.stim.entry.tag, r.stim.cset};
        alloc_req_id_i     <= r.stim.entry.req_id;
        alloc_src_id_i     <= r.stim.entry.src_id;
        alloc_word_i       <= r.stim.entry.word;
        alloc_victim_way_i <= r.stim.entry.victim_way;
        alloc_need_rsp_i   <= r.stim.entry.need_rsp;
        ack_set_i          <= r.ack_set;
        ack_way_i          <= r.ack_way;
    endtask

    function automatic mshr_entry_t ack_record();
        mshr_entry_t rec;
        rec.tag        = ack_cache_tag_o;
        rec.req_id     = ack_req_id_o;
        rec.src_id     = ack_src_id_o;
        rec.word       = ack_word_o;
        rec.victim_way = ack_cache_way_o;
        rec.need_rsp   = ack_need_rsp_o;
        return rec;
    endfunction

    // Outputs after the edge that executed row idx
    task automatic check_results(input int idx);
        row_t  r;
        string n;
        r = rows[idx];
        n = names[idx];
        if (r.check && !r.alloc && !r.ack) begin
            check_flag(n, "hit_o", r.exp_hit, hit_o);
            check_flag(n, "alloc_full_o", r.exp_afull, alloc_full_o);
        end
        if (r.ack) begin
            check_entry(n, r.exp_miss.entry, ack_record());
            check_cache_set(n, r.exp_miss.cset, ack_cache_set_o);
        end
        check_flag(n, "empty_o", r.exp_flags[1], empty_o);
        check_flag(n, "full_o", r.exp_flags[0], full_o);
    endtask

    initial begin
        rst_ni <= 1'b0;
        drive_row('0);
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_flag("after_reset", "empty_o", 1'b1, empty_o);
        check_flag("after_reset", "full_o", 1'b0, full_o);
        check_flag("after_reset", "hit_o", 1'b0, hit_o);
        check_flag("after_reset", "alloc_full_o", 1'b0, alloc_full_o);
        check_entry("after_reset", '0, ack_record());
        check_cache_set("after_reset", '0, ack_cache_set_o);
        // One extra pass drains the last row
        for (int i = 0; i <= rows.size(); i++) begin
            @(posedge clk_i);
            if (i < rows.size()) begin
                drive_row(rows[i]);
            end else begin
                drive_row('0);
            end
            @(negedge clk_i);
            if (i > 0) begin
                check_results(i - 1);
            end
            if (i < rows.size() && rows[i].alloc && !rows[i].ack) begin
                check_way(names[i], rows[i].exp_way, alloc_way_o);
            end
        end
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        wait (table_ready);
        repeat (rows.size() + RESET_CYCLES + 20) @(posedge clk_i);
        $display("Watchdog expired before the table was complete");
        abort_run();
    end

endmodule

/* source/mshr_top.sv */
/*
 * Miss status holding register, 4 sets by 2 ways, one request per cycle.
 * Acknowledge beats allocate beats check. No handshake; all requests complete.
 */
`timescale 1ns/10ps

module mshr_top
    import mshr_cfg_pkg::*, mshr_entry_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,

    output logic       empty_o,
    output logic       full_o,

    // Check
    input  logic       check_i,
    input  nline_t     check_nline_i,
    output logic       hit_o,
    output logic       alloc_full_o,

    // Allocate
    input  logic       alloc_i,
    input  nline_t     alloc_nline_i,
    input  req_id_t    alloc_req_id_i,
    input  src_id_t    alloc_src_id_i,
    input  word_t      alloc_word_i,
    input  cache_way_t alloc_victim_way_i,
    input  logic       alloc_need_rsp_i,
    output mshr_way_t  alloc_way_o,

    // Acknowledge
    input  logic       ack_i,
    input  mshr_set_t  ack_set_i,
    input  mshr_way_t  ack_way_i,
    output req_id_t    ack_req_id_o,
    output src_id_t    ack_src_id_o,
    output word_t      ack_word_o,
    output cache_way_t ack_cache_way_o,
    output tag_t       ack_cache_tag_o,
    output cache_set_t ack_cache_set_o,
    output logic       ack_need_rsp_o
);

    mshr_port_if port ();

    mshr_req_decode u_decode (
        .clk_i              (clk_i),
        .rst_ni             (rst_ni),
        .alloc_i            (alloc_i),
        .check_i            (check_i),
        .ack_i              (ack_i),
        .alloc_nline_i      (alloc_nline_i),
        .check_nline_i      (check_nline_i),
        .alloc_req_id_i     (alloc_req_id_i),
        .alloc_src_id_i     (alloc_src_id_i),
        .alloc_word_i       (alloc_word_i),
        .alloc_victim_way_i (alloc_victim_way_i),
        .alloc_need_rsp_i   (alloc_need_rsp_i),
        .ack_set_i          (ack_set_i),
        .ack_way_i          (ack_way_i),
        .alloc_way_o        (alloc_way_o),
        .port               (port)
    );

    mshr_entry_store u_store (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .port   (port)
    );

    mshr_lookup u_lookup (
        .port            (port),
        .hit_o           (hit_o),
        .alloc_full_o    (alloc_full_o),
        .empty_o         (empty_o),
        .full_o          (full_o),
        .ack_need_rsp_o  (ack_need_rsp_o),
        .ack_req_id_o    (ack_req_id_o),
        .ack_src_id_o    (ack_src_id_o),
        .ack_word_o      (ack_word_o),
        .ack_cache_way_o (ack_cache_way_o),
        .ack_cache_tag_o (ack_cache_tag_o),
        .ack_cache_set_o (ack_cache_set_o)
    );

endmodule

/* source/mshr_lookup.sv */
/*
 * Purely combinational. hit_o and alloc_full_o use the last checked line;
 * both follow later changes of the valid bits in that set.
 */
`timescale 1ns/10ps

module mshr_lookup
    import mshr_cfg_pkg::*, mshr_entry_pkg::*;
(
    mshr_port_if.lookup port,

    output logic       hit_o,
    output logic       alloc_full_o,
    output logic       empty_o,
    output logic       full_o,

    output logic       ack_need_rsp_o,
    output req_id_t    ack_req_id_o,
    output src_id_t    ack_src_id_o,
    output word_t      ack_word_o,
    output cache_way_t ack_cache_way_o,
    output tag_t       ack_cache_tag_o,
    output cache_set_t ack_cache_set_o
);

    logic [MSHR_WAYS-1:0] set_valid;
    logic [MSHR_WAYS-1:0] hit_way;
    mshr_entry_t          ack_entry;

    // A way hits only if tag and full cache set both match
    always_comb begin
        for (int w = 0; w < MSHR_WAYS; w++) begin
            set_valid[w] = port.valid[w][port.chk_set_q];
            hit_way[w]   = set_valid[w]
                        && (port.rd_entry[w].tag == port.chk_tag_q)
                        && (port.cache_set[w][port.chk_set_q] == port.chk_cache_set_q);
        end
    end

    assign hit_o        = |hit_way;
    assign alloc_full_o = &set_valid;

    // Record of the acknowledged way
    assign ack_entry       = port.rd_entry[port.ack_way_q];
    assign ack_req_id_o    = ack_entry.req_id;
    assign ack_src_id_o    = ack_entry.src_id;
    assign ack_word_o      = ack_entry.word;
    assign ack_cache_way_o = ack_entry.victim_way;
    assign ack_cache_tag_o = ack_entry.tag;
    assign ack_need_rsp_o  = ack_entry.need_rsp;
    assign ack_cache_set_o = port.ack_cache_set_q;

    // Global occupancy
    assign empty_o = ~|port.valid;
    assign full_o  = &port.valid;

endmodule

/* source/mshr_entry_store.sv */
/*
 * Valid bits and cache sets are flip-flops; entries sit in a synchronous-read array.
 * The read row is refreshed by every request, so read data holds only over idle cycles.
 */
`timescale 1ns/10ps

module mshr_entry_store
    import mshr_cfg_pkg::*, mshr_entry_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,

    mshr_port_if.store port
);

    logic        [MSHR_WAYS-1:0][MSHR_SETS-1:0] valid_q;
    cache_set_t  [MSHR_WAYS-1:0][MSHR_SETS-1:0] cache_set_q;
    mshr_entry_t [MSHR_WAYS-1:0]                entry_mem [MSHR_SETS];
    mshr_entry_t [MSHR_WAYS-1:0]                rd_entry_q;
    cache_set_t                                 ack_cache_set_q;

    logic do_alloc;
    logic do_ack;
    logic do_read;

    assign do_alloc = (port.op == OP_ALLOC);
    assign do_ack   = (port.op == OP_ACK);
    assign do_read  = (port.op != OP_NONE);

    // Slot state is set by allocate and cleared by acknowledge
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q     <= '0;
            cache_set_q <= '0;
        end else begin
            if (do_alloc) begin
                valid_q[port.alloc_way][port.access_set]     <= 1'b1;
                cache_set_q[port.alloc_way][port.access_set] <= port.wr_cache_set;
            end
            if (do_ack) begin
                valid_q[port.ack_way][port.ack_set] <= 1'b0;
            end
        end
    end

    // Entry array holds one record per way in each row
    always_ff @(posedge clk_i) begin
        if (do_alloc) begin
            entry_mem[port.access_set][port.alloc_way] <= port.wr_entry;
        end
    end

    // Whole row read back one cycle later
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_entry_q <= '0;
        end else if (do_read) begin
            rd_entry_q <= entry_mem[port.access_set];
        end
    end

    // Cache set of the freed slot is kept until the next acknowledge
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ack_cache_set_q <= '0;
        end else if (do_ack) begin
            ack_cache_set_q <= cache_set_q[port.ack_way][port.ack_set];
        end
    end

    assign port.valid           = valid_q;
    assign port.cache_set       = cache_set_q;
    assign port.rd_entry        = rd_entry_q;
    assign port.ack_cache_set_q = ack_cache_set_q;

endmodule

/* source/mshr_req_decode.sv */
/*
 * One request per cycle wins: acknowledge, then allocate, then check.
 * Allocating into a full set is not guarded; the caller checks first.
 */
`timescale 1ns/10ps

module mshr_req_decode
    import mshr_cfg_pkg::*, mshr_entry_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_ni,

    input  logic       alloc_i,
    input  logic       check_i,
    input  logic       ack_i,

    input  nline_t     alloc_nline_i,
    input  nline_t     check_nline_i,
    input  req_id_t    alloc_req_id_i,
    input  src_id_t    alloc_src_id_i,
    input  word_t      alloc_word_i,
    input  cache_way_t alloc_victim_way_i,
    input  logic       alloc_need_rsp_i,
    input  mshr_set_t  ack_set_i,
    input  mshr_way_t  ack_way_i,

    output mshr_way_t  alloc_way_o,

    mshr_port_if.decode port
);

    mshr_op_e  op;
    mshr_set_t alloc_set;
    mshr_set_t check_set;
    mshr_way_t free_way;

    // Fixed priority drops the losing requests
    always_comb begin
        if (ack_i) begin
            op = OP_ACK;
        end else if (alloc_i) begin
            op = OP_ALLOC;
        end else if (check_i) begin
            op = OP_CHECK;
        end else begin
            op = OP_NONE;
        end
    end

    assign alloc_set = alloc_nline_i[0 +: MSHR_SET_W];
    assign check_set = check_nline_i[0 +: MSHR_SET_W];

    // Row of the entry array touched this cycle
    always_comb begin
        case (op)
            OP_ACK:   port.access_set = ack_set_i;
            OP_ALLOC: port.access_set = alloc_set;
            default:  port.access_set = check_set;
        endcase
    end

    // Lowest free way wins as the scan runs from the top down
    always_comb begin
        free_way = '0;
        for (int w = MSHR_WAYS - 1; w >= 0; w--) begin
            if (!port.valid[w][alloc_set]) begin
                free_way = mshr_way_t'(w);
            end
        end
    end

    assign alloc_way_o    = free_way;
    assign port.alloc_way = free_way;
    assign port.op        = op;

    // The tag sits above the cache set in the line address
    assign port.wr_entry.tag        = alloc_nline_i[CACHE_SET_W +: TAG_W];
    assign port.wr_entry.req_id     = alloc_req_id_i;
    assign port.wr_entry.src_id     = alloc_src_id_i;
    assign port.wr_entry.word       = alloc_word_i;
    assign port.wr_entry.victim_way = alloc_victim_way_i;
    assign port.wr_entry.need_rsp   = alloc_need_rsp_i;
    assign port.wr_cache_set        = alloc_nline_i[0 +: CACHE_SET_W];

    assign port.ack_set = ack_set_i;
    assign port.ack_way = ack_way_i;

    // Context for the lookup in the following cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            port.chk_tag_q       <= '0;
            port.chk_cache_set_q <= '0;
            port.chk_set_q       <= '0;
            port.ack_way_q       <= '0;
        end else begin
            if (op == OP_CHECK) begin
                port.chk_tag_q       <= check_nline_i[CACHE_SET_W +: TAG_W];
                port.chk_cache_set_q <= check_nline_i[0 +: CACHE_SET_W];
                port.chk_set_q       <= check_set;
            end
            if (op == OP_ACK) begin
                port.ack_way_q <= ack_way_i;
            end
        end
    end

endmodule

/* source/mshr_port_if.sv */
/*
 * Internal bundle between request decode, entry store and lookup.
 * Valid and cache-set arrays are indexed [way][set].
 */
`timescale 1ns/10ps

interface mshr_port_if
    import mshr_cfg_pkg::*, mshr_entry_pkg::*;
();

    // Request side driven by the decoder
    mshr_op_e    op;
    mshr_set_t   access_set;
    mshr_way_t   alloc_way;
    mshr_entry_t wr_entry;
    cache_set_t  wr_cache_set;
    mshr_set_t   ack_set;
    mshr_way_t   ack_way;

    // Context of the last check and acknowledge
    tag_t        chk_tag_q;
    cache_set_t  chk_cache_set_q;
    mshr_set_t   chk_set_q;
    mshr_way_t   ack_way_q;

    // Storage state driven by the entry store
    logic        [MSHR_WAYS-1:0][MSHR_SETS-1:0] valid;
    cache_set_t  [MSHR_WAYS-1:0][MSHR_SETS-1:0] cache_set;
    mshr_entry_t [MSHR_WAYS-1:0]                rd_entry;
    cache_set_t                                 ack_cache_set_q;

    modport decode (
        input  valid,
        output op, access_set, alloc_way, wr_entry, wr_cache_set,
        output ack_set, ack_way,
        output chk_tag_q, chk_cache_set_q, chk_set_q, ack_way_q
    );

    modport store (
        input  op, access_set, alloc_way, wr_entry, wr_cache_set, ack_set, ack_way,
        output valid, cache_set, rd_entry, ack_cache_set_q
    );

    modport lookup (
        input op, access_set, alloc_way, wr_entry, wr_cache_set, ack_set, ack_way,
        input chk_tag_q, chk_cache_set_q, chk_set_q, ack_way_q,
        input valid, cache_set, rd_entry, ack_cache_set_q
    );

endinterface

/* source/mshr_entry_pkg.sv */
/*
 * Record kept per outstanding miss. The cache set is not part of it;
 * it lives in separate flip-flops next to the valid bits.
 */
package mshr_entry_pkg;
    import mshr_cfg_pkg::*;

    typedef logic [REQ_ID_W-1:0] req_id_t;
    typedef logic [SRC_ID_W-1:0] src_id_t;
    typedef logic [WORD_W-1:0]   word_t;

    // 17 bits as stored in the entry array
    typedef struct packed {
        tag_t       tag;
        req_id_t    req_id;
        src_id_t    src_id;
        word_t      word;
        cache_way_t victim_way;
        logic       need_rsp;
    } mshr_entry_t;

    // Winning request of the cycle, after priority
    typedef enum logic [1:0] {
        OP_NONE  = 2'd0,
        OP_CHECK = 2'd1,
        OP_ALLOC = 2'd2,
        OP_ACK   = 2'd3
    } mshr_op_e;

endpackage

/* source/mshr_cfg_pkg.sv */
/*
 * Fixed 4-set by 2-way holding register for a cache with 12-bit line addresses.
 * A line address is the tag above the cache set; the MSHR set is the low cache-set bits.
 */
package mshr_cfg_pkg;

    // Cache address geometry
    localparam int CACHE_SET_W = 6;
    localparam int TAG_W       = 6;
    localparam int NLINE_W     = TAG_W + CACHE_SET_W;
    localparam int CACHE_WAY_W = 2;

    // Holding register geometry
    localparam int MSHR_SETS  = 4;
    localparam int MSHR_WAYS  = 2;
    localparam int MSHR_SET_W = 2;
    localparam int MSHR_WAY_W = 1;

    // Request context widths
    localparam int REQ_ID_W = 4;
    localparam int SRC_ID_W = 2;
    localparam int WORD_W   = 2;

    typedef logic [NLINE_W-1:0]     nline_t;
    typedef logic [CACHE_SET_W-1:0] cache_set_t;
    typedef logic [TAG_W-1:0]       tag_t;
    typedef logic [MSHR_SET_W-1:0]  mshr_set_t;
    typedef logic [MSHR_WAY_W-1:0]  mshr_way_t;
    typedef logic [CACHE_WAY_W-1:0] cache_way_t;

endpackage
